/* vdiv_defs.svh */
// vector divide defines

`ifndef VDIV_DEFS_SVH
`define VDIV_DEFS_SVH

// operand width in bits, one 32-bit word per transfer
`define VDIV_OP_W   32

// byte lanes of the write mask
`define VDIV_BYTES  4

// divider lanes, one per byte so 8-bit elements all fit
`define VDIV_LANES  4

`endif

/* vdiv_pkg.sv */
// vector divide types

`include "vdiv_defs.svh"

package vdiv_pkg;

    //////////////////////////////
    // encodings

    typedef enum logic [1:0] {
        VSEW_8  = 2'b00,
        VSEW_16 = 2'b01,
        VSEW_32 = 2'b10
    } vsew_e;

    typedef enum logic {
        DIV_VDIV = 1'b0,    // quotient
        DIV_VREM = 1'b1     // remainder
    } div_op_e;

    //////////////////////////////
    // pipeline payloads

    // travels alongside every item through all stages
    typedef struct packed {
        vsew_e       eew;
        div_op_e     op;
        logic        op1_signed;
        logic        op2_signed;
        logic        masked;      // apply mask_i
        logic        vl_zero;     // no active bytes
        logic [1:0]  vl_last;     // index of last active byte
        logic [5:0]  tag;         // opaque, passed through
    } vdiv_ctrl_t;

    // one extra bit so unsigned 32-bit operands stay positive
    typedef struct packed {
        logic [`VDIV_OP_W:0] dividend;
        logic [`VDIV_OP_W:0] divisor;
    } vdiv_lane_t;

endpackage

/* vdiv_lane.sv */
// signed divider lane

`timescale 1ns/1ps

`include "vdiv_defs.svh"

module vdiv_lane (
    input  logic [`VDIV_OP_W:0]   dividend_i,
    input  logic [`VDIV_OP_W:0]   divisor_i,
    output logic [`VDIV_OP_W-1:0] quot_o,
    output logic [`VDIV_OP_W-1:0] rem_o
);

    logic                       div_zero;
    logic signed [`VDIV_OP_W:0] divisor_safe;
    logic signed [`VDIV_OP_W:0] quot;
    logic signed [`VDIV_OP_W:0] rem;

    assign div_zero = (divisor_i == '0);

    // keeps the divider free of x when the result is overridden anyway
    assign divisor_safe = div_zero ? 33'sd1 : $signed(divisor_i);

    // overflow case fits in 33 bits, truncation gives the dividend back
    assign quot = $signed(dividend_i) / divisor_safe;
    assign rem  = $signed(dividend_i) % divisor_safe;

    // zero divisor, RISC-V V rules
    assign quot_o = div_zero ? '1 : quot[`VDIV_OP_W-1:0];
    assign rem_o  = div_zero ? dividend_i[`VDIV_OP_W-1:0] : rem[`VDIV_OP_W-1:0];

endmodule

/* vdiv_operand_stage.sv */
// vector divide operand stage

`timescale 1ns/1ps

`include "vdiv_defs.svh"

module vdiv_operand_stage import vdiv_pkg::*; (
    input  logic                              clk_i,
    input  logic                              async_rst_ni,

    input  logic                              valid_i,
    output logic                              ready_o,
    input  vdiv_ctrl_t                        ctrl_i,
    input  logic [`VDIV_OP_W-1:0]             op1_i,
    input  logic [`VDIV_OP_W-1:0]             op2_i,
    input  logic [`VDIV_BYTES-1:0]            mask_i,

    output logic                              valid_o,
    input  logic                              ready_i,
    output vdiv_ctrl_t                        ctrl_o,
    output vdiv_lane_t [`VDIV_LANES-1:0]      lanes_o,
    output logic [`VDIV_BYTES-1:0]            wmask_o
);

    logic                          valid_q;
    vdiv_lane_t [`VDIV_LANES-1:0]  lanes_d;
    logic [`VDIV_BYTES-1:0]        sign1, sign2;
    logic [`VDIV_BYTES-1:0]        vl_mask;
    logic [`VDIV_BYTES-1:0]        wmask_d;

    //////////////////////////////
    // element extension

    // top bit of every byte, only meaningful where an element ends
    always_comb begin
        for (int i = 0; i < `VDIV_BYTES; i++) begin
            sign1[i] = ctrl_i.op1_signed & op1_i[8*i+7];
            sign2[i] = ctrl_i.op2_signed & op2_i[8*i+7];
        end
    end

    always_comb begin
        for (int i = 0; i < `VDIV_LANES; i++) begin
            lanes_d[i].dividend = '0;
            lanes_d[i].divisor  = 33'd1;    // idle lanes never divide by zero
        end
        case (ctrl_i.eew)
            VSEW_8: begin
                for (int i = 0; i < 4; i++) begin
                    lanes_d[i].dividend = {{25{sign1[i]}}, op1_i[8*i +: 8]};
                    lanes_d[i].divisor  = {{25{sign2[i]}}, op2_i[8*i +: 8]};
                end
            end
            VSEW_16: begin
                for (int i = 0; i < 2; i++) begin
                    lanes_d[i].dividend = {{17{sign1[2*i+1]}}, op1_i[16*i +: 16]};
                    lanes_d[i].divisor  = {{17{sign2[2*i+1]}}, op2_i[16*i +: 16]};
                end
            end
            VSEW_32: begin
                lanes_d[0].dividend = {sign1[3], op1_i};
                lanes_d[0].divisor  = {sign2[3], op2_i};
            end
            default: ;
        endcase
    end

    // bytes 0..vl_last active
    assign vl_mask = ctrl_i.vl_zero ? '0 : (4'b1111 >> (~ctrl_i.vl_last));
    assign wmask_d = vl_mask & (ctrl_i.masked ? mask_i : '1);

    //////////////////////////////
    // stage register

    assign ready_o = ~valid_q | ready_i;

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            valid_q <= 1'b0;
        end else if (ready_o) begin
            valid_q <= valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (valid_i && ready_o) begin
            ctrl_o  <= ctrl_i;
            lanes_o <= lanes_d;
            wmask_o <= wmask_d;
        end
    end

    assign valid_o = valid_q;

endmodule

/* vdiv_lane_array.sv */
// vector divide lane array

`timescale 1ns/1ps

`include "vdiv_defs.svh"

module vdiv_lane_array import vdiv_pkg::*; (
    input  logic                                        clk_i,
    input  logic                                        async_rst_ni,

    input  logic                                        valid_i,
    output logic                                        ready_o,
    input  vdiv_ctrl_t                                  ctrl_i,
    input  vdiv_lane_t [`VDIV_LANES-1:0]                lanes_i,
    input  logic [`VDIV_BYTES-1:0]                      wmask_i,

    output logic                                        valid_o,
    input  logic                                        ready_i,
    output vdiv_ctrl_t                                  ctrl_o,
    output logic [`VDIV_LANES-1:0][`VDIV_OP_W-1:0]      quot_o,
    output logic [`VDIV_LANES-1:0][`VDIV_OP_W-1:0]      rem_o,
    output logic [`VDIV_BYTES-1:0]                      wmask_o
);

    logic                                   valid_q;
    logic [`VDIV_LANES-1:0][`VDIV_OP_W-1:0] quot_d;
    logic [`VDIV_LANES-1:0][`VDIV_OP_W-1:0] rem_d;

    // one divider per lane, all combinational
    for (genvar g = 0; g < `VDIV_LANES; g++) begin : g_lane
        vdiv_lane u_lane (
            .dividend_i (lanes_i[g].dividend),
            .divisor_i  (lanes_i[g].divisor),
            .quot_o     (quot_d[g]),
            .rem_o      (rem_d[g])
        );
    end

    //////////////////////////////
    // middle pipeline register

    assign ready_o = ~valid_q | ready_i;

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            valid_q <= 1'b0;
        end else if (ready_o) begin
            valid_q <= valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (valid_i && ready_o) begin
            ctrl_o  <= ctrl_i;
            quot_o  <= quot_d;
            rem_o   <= rem_d;
            wmask_o <= wmask_i;     // mask rides along unchanged
        end
    end

    assign valid_o = valid_q;

endmodule

/* vdiv_result_stage.sv */
// vector divide result stage

`timescale 1ns/1ps

`include "vdiv_defs.svh"

module vdiv_result_stage import vdiv_pkg::*; (
    input  logic                                        clk_i,
    input  logic                                        async_rst_ni,

    input  logic                                        valid_i,
    output logic                                        ready_o,
    input  vdiv_ctrl_t                                  ctrl_i,
    input  logic [`VDIV_LANES-1:0][`VDIV_OP_W-1:0]      quot_i,
    input  logic [`VDIV_LANES-1:0][`VDIV_OP_W-1:0]      rem_i,
    input  logic [`VDIV_BYTES-1:0]                      wmask_i,

    output logic                                        valid_o,
    input  logic                                        ready_i,
    output vdiv_ctrl_t                                  ctrl_o,
    output logic [`VDIV_OP_W-1:0]                       res_o,
    output logic [`VDIV_BYTES-1:0]                      wmask_o
);

    logic                                   valid_q;
    logic [`VDIV_LANES-1:0][`VDIV_OP_W-1:0] sel;
    logic [`VDIV_OP_W-1:0]                  res_d;

    //////////////////////////////
    // result packing

    assign sel = (ctrl_i.op == DIV_VREM) ? rem_i : quot_i;

    // low element bits of each used lane
    always_comb begin
        res_d = '0;
        case (ctrl_i.eew)
            VSEW_8: begin
                for (int i = 0; i < 4; i++) begin
                    res_d[8*i +: 8] = sel[i][7:0];
                end
            end
            VSEW_16: begin
                for (int i = 0; i < 2; i++) begin
                    res_d[16*i +: 16] = sel[i][15:0];
                end
            end
            VSEW_32: res_d = sel[0];
            default: ;
        endcase
    end

    //////////////////////////////
    // output register

    assign ready_o = ~valid_q | ready_i;

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            valid_q <= 1'b0;
        end else if (ready_o) begin
            valid_q <= valid_i;
        end
    end

    // held while downstream stalls
    always_ff @(posedge clk_i) begin
        if (valid_i && ready_o) begin
            ctrl_o  <= ctrl_i;
            res_o   <= res_d;
            wmask_o <= wmask_i;
        end
    end

    assign valid_o = valid_q;

endmodule

/* vdiv_unit.sv */
// vector divide unit top

`timescale 1ns/1ps

`include "vdiv_defs.svh"

module vdiv_unit import vdiv_pkg::*; (
    input  logic                    clk_i,
    input  logic                    async_rst_ni,

    input  logic                    in_valid_i,
    output logic                    in_ready_o,
    input  vdiv_ctrl_t              in_ctrl_i,
    input  logic [`VDIV_OP_W-1:0]   in_op1_i,
    input  logic [`VDIV_OP_W-1:0]   in_op2_i,
    input  logic [`VDIV_BYTES-1:0]  in_mask_i,

    output logic                    out_valid_o,
    input  logic                    out_ready_i,
    output vdiv_ctrl_t              out_ctrl_o,
    output logic [`VDIV_OP_W-1:0]   out_res_o,
    output logic [`VDIV_BYTES-1:0]  out_mask_o
);

    // operand stage -> lane array
    logic                                   op_valid;
    logic                                   op_ready;
    vdiv_ctrl_t                             op_ctrl;
    vdiv_lane_t [`VDIV_LANES-1:0]           op_lanes;
    logic [`VDIV_BYTES-1:0]                 op_wmask;

    // lane array -> result stage
    logic                                   dv_valid;
    logic                                   dv_ready;
    vdiv_ctrl_t                             dv_ctrl;
    logic [`VDIV_LANES-1:0][`VDIV_OP_W-1:0] dv_quot;
    logic [`VDIV_LANES-1:0][`VDIV_OP_W-1:0] dv_rem;
    logic [`VDIV_BYTES-1:0]                 dv_wmask;

    vdiv_operand_stage u_operand (
        .clk_i        (clk_i),
        .async_rst_ni (async_rst_ni),
        .valid_i      (in_valid_i),
        .ready_o      (in_ready_o),
        .ctrl_i       (in_ctrl_i),
        .op1_i        (in_op1_i),
        .op2_i        (in_op2_i),
        .mask_i       (in_mask_i),
        .valid_o      (op_valid),
        .ready_i      (op_ready),
        .ctrl_o       (op_ctrl),
        .lanes_o      (op_lanes),
        .wmask_o      (op_wmask)
    );

    vdiv_lane_array u_lanes (
        .clk_i        (clk_i),
        .async_rst_ni (async_rst_ni),
        .valid_i      (op_valid),
        .ready_o      (op_ready),
        .ctrl_i       (op_ctrl),
        .lanes_i      (op_lanes),
        .wmask_i      (op_wmask),
        .valid_o      (dv_valid),
        .ready_i      (dv_ready),
        .ctrl_o       (dv_ctrl),
        .quot_o       (dv_quot),
        .rem_o        (dv_rem),
        .wmask_o      (dv_wmask)
    );

    vdiv_result_stage u_result (
        .clk_i        (clk_i),
        .async_rst_ni (async_rst_ni),
        .valid_i      (dv_valid),
        .ready_o      (dv_ready),
        .ctrl_i       (dv_ctrl),
        .quot_i       (dv_quot),
        .rem_i        (dv_rem),
        .wmask_i      (dv_wmask),
        .valid_o      (out_valid_o),
        .ready_i      (out_ready_i),
        .ctrl_o       (out_ctrl_o),
        .res_o        (out_res_o),
        .wmask_o      (out_mask_o)
    );

endmodule

/* vdiv_chk.sv */
// vector divide output checks

`timescale 1ns/1ps

`include "vdiv_defs.svh"

module vdiv_chk import vdiv_pkg::*; (
    input logic                   clk_i,
    input logic                   async_rst_ni,
    input logic                   out_valid_o,
    input logic                   out_ready_i,
    input vdiv_ctrl_t             out_ctrl_o,
    input logic [`VDIV_OP_W-1:0]  out_res_o,
    input logic [`VDIV_BYTES-1:0] out_mask_o
);

    //////////////////////////////
    // handshake

    // stalled output holds
    a_out_stable: assert property (@(posedge clk_i) disable iff (!async_rst_ni)
        out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_res_o) &&
        $stable(out_ctrl_o) && $stable(out_mask_o))
        else $error("output changed while stalled");

    a_reset_idle: assert property (@(posedge clk_i)
        !async_rst_ni |-> !out_valid_o)
        else $error("out_valid_o high in reset");

    //////////////////////////////
    // mask

    a_mask_range: assert property (@(posedge clk_i) disable iff (!async_rst_ni)
        out_valid_o |-> ((out_mask_o >> ({1'b0, out_ctrl_o.vl_last} + 3'd1)) == '0))
        else $error("mask bit above vl_last");

    a_mask_zero: assert property (@(posedge clk_i) disable iff (!async_rst_ni)
        out_valid_o && out_ctrl_o.vl_zero |-> out_mask_o == '0)
        else $error("mask set with vl_zero");

endmodule

bind vdiv_unit vdiv_chk u_chk (.*);

/* vdiv_tb.sv */
// vector divide testbench

`timescale 1ns/1ps

`include "vdiv_defs.svh"

module vdiv_tb import vdiv_pkg::*; ();

    localparam int TIMEOUT = 200;

    typedef struct packed {
        logic [31:0] res;
        logic [3:0]  mask;
        vdiv_ctrl_t  ctrl;
    } exp_t;

    logic                   clk_i;
    logic                   async_rst_ni;
    logic                   in_valid_i;
    logic                   in_ready_o;
    vdiv_ctrl_t             in_ctrl_i;
    logic [`VDIV_OP_W-1:0]  in_op1_i;
    logic [`VDIV_OP_W-1:0]  in_op2_i;
    logic [`VDIV_BYTES-1:0] in_mask_i;
    logic                   out_valid_o;
    logic                   out_ready_i;
    vdiv_ctrl_t             out_ctrl_o;
    logic [`VDIV_OP_W-1:0]  out_res_o;
    logic [`VDIV_BYTES-1:0] out_mask_o;

    exp_t        exp_q[$];
    logic [31:0] lfsr_state = 32'h161ab664;
    logic        ready_rand = 1'b0;
    int          n_stall = 0;
    logic [5:0]  tag_cnt = '0;

    vdiv_unit u_dut (.*);

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    //////////////////////////////
    // helpers

    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // one step per bit taken
    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic longint extend(longint unsigned e, int w, logic sgn);
        if (sgn && ((e >> (w - 1)) & 64'd1) != 0) begin
            return longint'(e) - longint'(64'd1 << w);
        end
        return longint'(e);
    endfunction

    // expected result straight from the RISC-V V divide rules
    function automatic exp_t ref_model(vdiv_ctrl_t c, logic [31:0] a, logic [31:0] b,
                                       logic [3:0] m);
        exp_t          e;
        int            w;
        longint unsigned emask;
        longint        x;
        longint        y;
        longint        q;
        longint        r;
        longint        v;
        e.res  = '0;
        e.ctrl = c;
        w = (c.eew == VSEW_8) ? 8 : (c.eew == VSEW_16) ? 16 : 32;
        emask = (64'd1 << w) - 64'd1;
        for (int k = 0; k < 32 / w; k++) begin
            x = extend((64'(a) >> (k * w)) & emask, w, c.op1_signed);
            y = extend((64'(b) >> (k * w)) & emask, w, c.op2_signed);
            if (y == 0) begin
                q = -1;
                r = x;
            end else if (c.op1_signed && c.op2_signed && y == -1 &&
                         x == -longint'(64'd1 << (w - 1))) begin
                q = x;                  // signed overflow
                r = 0;
            end else begin
                q = x / y;
                r = x % y;
            end
            v = (c.op == DIV_VREM) ? r : q;
            e.res = e.res | 32'((longint'(v) & emask) << (k * w));
        end
        for (int i = 0; i < 4; i++) begin
            e.mask[i] = !c.vl_zero && (i <= int'(c.vl_last)) && (!c.masked || m[i]);
        end
        return e;
    endfunction

    task automatic abort_run(string what);
        $display("ERROR at %0t: %s", $time, what);
        $display("*** FAILED ***");
        $fatal(1);
    endtask

    task automatic check_eq(string name, logic [31:0] exp, logic [31:0] got);
        assert (exp === got) else begin
            $display("FAILED t=%0t %s expected=%h actual=%h", $time, name, exp, got);
            $display("*** FAILED ***");
            $fatal(1);
        end
    endtask

    function automatic vdiv_ctrl_t make_ctrl(vsew_e eew, div_op_e op, logic s1, logic s2,
                                             logic masked, logic vz, logic [1:0] last);
        vdiv_ctrl_t c;
        c.eew        = eew;
        c.op         = op;
        c.op1_signed = s1;
        c.op2_signed = s2;
        c.masked     = masked;
        c.vl_zero    = vz;
        c.vl_last    = last;
        c.tag        = '0;
        return c;
    endfunction

    // holds valid until the DUT takes the item
    task automatic send_item(vdiv_ctrl_t c, logic [31:0] a, logic [31:0] b, logic [3:0] m);
        int   cnt;
        logic ok;
        cnt = 0;
        ok  = 1'b0;
        c.tag = tag_cnt;
        tag_cnt = tag_cnt + 6'd1;
        @(posedge clk_i);
        in_valid_i <= 1'b1;
        in_ctrl_i  <= c;
        in_op1_i   <= a;
        in_op2_i   <= b;
        in_mask_i  <= m;
        while (!ok) begin
            @(negedge clk_i);
            ok = in_ready_o;
            if (!ok) begin
                cnt++;
                assert (cnt < TIMEOUT) else abort_run("in_ready_o stuck low");
            end
        end
        exp_q.push_back(ref_model(c, a, b, m));
        @(posedge clk_i);
        in_valid_i <= 1'b0;
    endtask

    task automatic wait_drain();
        int cnt;
        cnt = 0;
        while (exp_q.size() != 0) begin
            @(negedge clk_i);
            cnt++;
            assert (cnt < TIMEOUT) else abort_run("pipeline did not drain");
        end
    endtask

    //////////////////////////////
    // scoreboard

    always @(negedge clk_i) begin
        exp_t e;
        if (async_rst_ni) begin
            if (out_valid_o && out_ready_i) begin
                assert (exp_q.size() != 0) else abort_run("result with no item outstanding");
                e = exp_q.pop_front();
                check_eq("out_ctrl_o.tag", 32'(e.ctrl.tag), 32'(out_ctrl_o.tag));
                check_eq("out_ctrl_o", 32'(e.ctrl), 32'(out_ctrl_o));
                check_eq("out_res_o", e.res, out_res_o);
                check_eq("out_mask_o", 32'(e.mask), 32'(out_mask_o));
            end
            if (!in_ready_o) begin
                assert (exp_q.size() == 3 && out_valid_o && !out_ready_i)
                    else abort_run("in_ready_o low while pipeline not full");
                n_stall++;
            end
        end
    end

    // pseudo-random back-pressure when enabled
    always @(posedge clk_i) begin
        if (ready_rand) begin
            out_ready_i <= (rand_bits(1) != 0);
        end else begin
            out_ready_i <= 1'b1;
        end
    end

    //////////////////////////////
    // tests

    task automatic test_unsigned_8();
        send_item(make_ctrl(VSEW_8, DIV_VDIV, 0, 0, 0, 0, 2'd3), 32'hc864ff07, 32'h070a1003, 4'h0);
        send_item(make_ctrl(VSEW_8, DIV_VREM, 0, 0, 0, 0, 2'd3), 32'hc864ff07, 32'h070a1003, 4'h0);
        send_item(make_ctrl(VSEW_8, DIV_VDIV, 0, 0, 0, 0, 2'd3), 32'h80fe0164, 32'hff0201c8, 4'h0);
        wait_drain();
    endtask

    task automatic test_signed();
        send_item(make_ctrl(VSEW_16, DIV_VDIV, 1, 1, 0, 0, 2'd3), 32'h8000fff9, 32'hffff0002, 4'h0);
        send_item(make_ctrl(VSEW_16, DIV_VREM, 1, 1, 0, 0, 2'd3), 32'h8000fff9, 32'hffff0002, 4'h0);
        send_item(make_ctrl(VSEW_32, DIV_VDIV, 1, 1, 0, 0, 2'd3), 32'h80000000, 32'hffffffff, 4'h0);
        send_item(make_ctrl(VSEW_32, DIV_VREM, 1, 1, 0, 0, 2'd3), 32'h80000000, 32'hffffffff, 4'h0);
        send_item(make_ctrl(VSEW_32, DIV_VREM, 1, 1, 0, 0, 2'd3), 32'd100, 32'hfffffff9, 4'h0);
        send_item(make_ctrl(VSEW_8, DIV_VDIV, 1, 1, 0, 0, 2'd3), 32'h80f97f10, 32'hff02fdfd, 4'h0);
        wait_drain();
    endtask

    task automatic test_div_zero();
        vsew_e ew[3];
        ew = '{VSEW_8, VSEW_16, VSEW_32};
        for (int i = 0; i < 3; i++) begin
            send_item(make_ctrl(ew[i], DIV_VDIV, 1, 1, 0, 0, 2'd3), 32'h8123f456, 32'h0, 4'h0);
            send_item(make_ctrl(ew[i], DIV_VREM, 0, 0, 0, 0, 2'd3), 32'h8123f456, 32'h0, 4'h0);
        end
        wait_drain();
    endtask

    task automatic test_mask();
        for (int mk = 0; mk < 2; mk++) begin
            for (int vz = 0; vz < 2; vz++) begin
                for (int last = 0; last < 4; last++) begin
                    for (int m = 0; m < 16; m += 5) begin
                        send_item(make_ctrl(VSEW_8, DIV_VDIV, 0, 0, mk[0], vz[0], last[1:0]),
                                  32'h40302010, 32'h04030201, m[3:0]);
                    end
                end
            end
        end
        wait_drain();
    endtask

    task automatic test_latency();
        vdiv_ctrl_t c;
        c = make_ctrl(VSEW_32, DIV_VDIV, 0, 0, 0, 0, 2'd3);
        c.tag = tag_cnt;
        tag_cnt = tag_cnt + 6'd1;
        wait_drain();
        @(posedge clk_i);                   // item driven on edge N
        in_valid_i <= 1'b1;
        in_ctrl_i  <= c;
        in_op1_i   <= 32'd1000;
        in_op2_i   <= 32'd7;
        in_mask_i  <= 4'h0;
        @(negedge clk_i);
        assert (in_ready_o) else abort_run("in_ready_o low on an empty pipeline");
        exp_q.push_back(ref_model(c, 32'd1000, 32'd7, 4'h0));
        // accepting edge loads the first of three stage registers
        for (int k = 1; k <= 3; k++) begin
            @(posedge clk_i);
            if (k == 1) begin
                in_valid_i <= 1'b0;
            end
            @(negedge clk_i);
            assert (out_valid_o == (k == 3))
                else abort_run("out_valid_o not high exactly after edge N+3");
        end
        wait_drain();
    endtask

    task automatic test_stream();
        vdiv_ctrl_t c;
        logic [1:0] ew;
        ready_rand = 1'b1;
        for (int i = 0; i < 200; i++) begin
            ew = 2'(rand_bits(2));
            if (ew == 2'd3) ew = 2'd2;
            c = make_ctrl(vsew_e'(ew), div_op_e'(1'(rand_bits(1))), rand_bits(1) != 0,
                          rand_bits(1) != 0, rand_bits(1) != 0, rand_bits(3) == 0,
                          2'(rand_bits(2)));
            send_item(c, rand_bits(32), (rand_bits(3) == 0) ? 32'h0 : rand_bits(32),
                      4'(rand_bits(4)));
        end
        ready_rand = 1'b0;
        wait_drain();
        assert (n_stall != 0) else abort_run("back-pressure never filled the pipeline");
    endtask

    initial begin
        async_rst_ni = 1'b0;
        in_valid_i   = 1'b0;
        in_ctrl_i    = '0;
        in_op1_i     = '0;
        in_op2_i     = '0;
        in_mask_i    = '0;
        out_ready_i  = 1'b1;
        repeat (5) @(posedge clk_i);
        async_rst_ni <= 1'b1;
        @(negedge clk_i);
        assert (!out_valid_o && in_ready_o) else abort_run("bad state after reset");

        test_unsigned_8();
        test_signed();
        test_div_zero();
        test_mask();
        test_latency();
        test_stream();

        $display("*** PASSED ***");
        $finish;
    end

endmodule

/* files.f */
+incdir+.
vdiv_pkg.sv
vdiv_lane.sv
vdiv_operand_stage.sv
vdiv_lane_array.sv
vdiv_result_stage.sv
vdiv_unit.sv
vdiv_chk.sv
vdiv_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the vector divide simulation with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module vdiv_tb \
    -f files.f \
    -o vdiv_sim

# the simulator exits nonzero on a fatal error, the log decides
./obj_dir/vdiv_sim > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q -F '*** FAILED ***' "$LOG"; then
    echo "simulation failed"
    exit 1
fi

if ! grep -q -F '*** PASSED ***' "$LOG"; then
    echo "simulation did not complete"
    exit 1
fi

echo "simulation passed"
